// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert
TOP      := tb_fabric
FILELIST := sim.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/cfg_link_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cfg_link_if;

  // Shift one bit this cycle
  logic shift_en;
  // Copy shift stages into shadow registers
  logic latch;
  // Fabric flip-flops may update
  logic run;
  // Serial configuration bit
  logic sdata;

  // Sender side of a hop
  modport upstream (
    output shift_en,
    output latch,
    output run,
    output sdata
  );

  // Receiver side of a hop
  modport downstream (
    input shift_en,
    input latch,
    input run,
    input sdata
  );

endinterface

`default_nettype wire

// File: hw/cfg_loader.sv
`timescale 1ns/1ps
`default_nettype none
`include "fabric_macros.svh"

module cfg_loader
  import fabric_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic cen,
  input  logic cset,
  input  logic shift_in,
  input  logic en,
  output logic cfg_valid,
  output logic cfg_error,
  cfg_link_if.upstream link
);

  localparam logic [`FAB_CNT_W-1:0] CFG_TOTAL = `FAB_CNT_W'(`FAB_CFG_TOTAL);

  ldr_state_e state_q;
  ldr_state_e state_d;
  logic [`FAB_CNT_W-1:0] bit_cnt;
  logic cnt_ok;

  // Full chain shifted since the last cset
  assign cnt_ok = (state_q == LDR_SHIFTING) && (bit_cnt == CFG_TOTAL);

  // Serial data goes straight into the chain
  assign link.shift_en = cen;
  assign link.sdata    = shift_in;
  // Only a qualified cset reaches the shadow registers
  assign link.latch    = cset & cnt_ok;
  // Logic runs only on a good configuration
  assign link.run      = en & cfg_valid;

  always_comb begin
    state_d = state_q;
    // cset ends a load, good or bad
    if (cset) begin
      state_d = cnt_ok ? LDR_LOADED : LDR_ERROR;
    end else if (cen) begin
      state_d = LDR_SHIFTING;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= LDR_IDLE;
      bit_cnt   <= '0;
      cfg_valid <= 1'b0;
      cfg_error <= 1'b0;
    end else begin
      state_q <= state_d;
      // Count restarts on every cset
      if (cset) begin
        bit_cnt <= '0;
      end else if (cen && (bit_cnt != '1)) begin
        // Saturate so long streams never wrap to a legal count
        bit_cnt <= bit_cnt + 1'b1;
      end
      // Status follows the latch decision
      if (cset) begin
        cfg_valid <= cnt_ok;
        cfg_error <= !cnt_ok;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/fabric_pkg.sv
`default_nettype none

package fabric_pkg;

  // Source of one LUT input
  typedef enum logic [2:0] {
    SRC_WEST0 = 3'd0,
    SRC_WEST1 = 3'd1,
    SRC_WEST2 = 3'd2,
    SRC_WEST3 = 3'd3,
    // Pads local to this tile
    SRC_PAD0  = 3'd4,
    SRC_PAD1  = 3'd5,
    // Own output flip-flop, for feedback
    SRC_FF    = 3'd6,
    SRC_ZERO  = 3'd7
  } lut_src_e;

  // What one output pin shows
  typedef enum logic [1:0] {
    PIN_LUT  = 2'd0,
    PIN_FF   = 2'd1,
    // Lane of the last east bus with the pin's index
    PIN_LANE = 2'd2,
    PIN_OFF  = 2'd3
  } pin_mode_e;

  // Configuration loader state
  typedef enum logic [1:0] {
    LDR_IDLE     = 2'd0,
    LDR_SHIFTING = 2'd1,
    LDR_LOADED   = 2'd2,
    LDR_ERROR    = 2'd3
  } ldr_state_e;

endpackage

`default_nettype wire

// File: hw/fabric_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fabric_macros.svh"

module fabric_top (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             en,
  input  logic                             cen,
  input  logic                             cset,
  input  logic                             shift_in,
  input  logic [`FAB_LANES-1:0]            pad_west,
  input  logic [`FAB_TILES*`FAB_PADS-1:0]  pad_in,
  output logic                             shift_out,
  output logic                             cfg_valid,
  output logic                             cfg_error,
  output logic [`FAB_TILES-1:0]            gpio_out
);

  // One config hop per chain link, loader first
  cfg_link_if hop [`FAB_TILES+1] ();

  // Routing lanes between tiles, entry 0 is the west edge
  logic [`FAB_TILES:0][`FAB_LANES-1:0] lane_bus;
  logic [`FAB_TILES-1:0] lut_vec;
  logic [`FAB_TILES-1:0] ff_vec;

  assign lane_bus[0] = pad_west;

  // Chain head and status
  cfg_loader u_loader (
    .clk       (clk),
    .arst_n    (arst_n),
    .cen       (cen),
    .cset      (cset),
    .shift_in  (shift_in),
    .en        (en),
    .cfg_valid (cfg_valid),
    .cfg_error (cfg_error),
    .link      (hop[0])
  );

  // Row of logic tiles, west to east
  for (genvar t = 0; t < `FAB_TILES; t++) begin : g_tile
    logic_tile u_tile (
      .clk      (clk),
      .arst_n   (arst_n),
      .up       (hop[t]),
      .down     (hop[t+1]),
      .west_bus (lane_bus[t]),
      .pads     (pad_in[t*`FAB_PADS +: `FAB_PADS]),
      .east_bus (lane_bus[t+1]),
      .lut_out  (lut_vec[t]),
      .ff_out   (ff_vec[t])
    );
  end

  // Output pins and chain tail
  pad_out_stage u_pads (
    .clk       (clk),
    .arst_n    (arst_n),
    .up        (hop[`FAB_TILES]),
    .lut_outs  (lut_vec),
    .ff_outs   (ff_vec),
    .last_east (lane_bus[`FAB_TILES]),
    .gpio_out  (gpio_out),
    .shift_out (shift_out)
  );

endmodule

`default_nettype wire

// File: hw/logic_tile.sv
`timescale 1ns/1ps
`default_nettype none
`include "fabric_macros.svh"

module logic_tile
  import fabric_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  cfg_link_if.downstream        up,
  cfg_link_if.upstream          down,
  input  logic [`FAB_LANES-1:0] west_bus,
  input  logic [`FAB_PADS-1:0]  pads,
  output logic [`FAB_LANES-1:0] east_bus,
  output logic                  lut_out,
  output logic                  ff_out
);

  localparam int SEL_W   = 3;
  localparam int LUT_K   = 4;
  localparam int TT_LSB  = LUT_K * SEL_W;
  localparam int TT_W    = 1 << LUT_K;
  localparam int USE_BIT = `TILE_CFG_BITS - 1;

  logic [`TILE_CFG_BITS-1:0] shift_q;
  logic [`TILE_CFG_BITS-1:0] cfg_q;
  lut_src_e sel [LUT_K];
  logic [LUT_K-1:0] lut_in;
  logic [TT_W-1:0] truth;
  logic use_ff;
  logic ff_q;
  logic tile_out;

  // One LUT input from its configured source
  function automatic logic pick_src(
    input lut_src_e             src,
    input logic [`FAB_LANES-1:0] west,
    input logic [`FAB_PADS-1:0]  pad,
    input logic                 ff
  );
    logic bit_v;
    case (src)
      SRC_WEST0: bit_v = west[0];
      SRC_WEST1: bit_v = west[1];
      SRC_WEST2: bit_v = west[2];
      SRC_WEST3: bit_v = west[3];
      SRC_PAD0:  bit_v = pad[0];
      SRC_PAD1:  bit_v = pad[1];
      SRC_FF:    bit_v = ff;
      default:   bit_v = 1'b0;
    endcase
    return bit_v;
  endfunction

  // Config segment, new bit enters at the low end
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shift_q <= '0;
      cfg_q   <= '0;
    end else begin
      if (up.shift_en) begin
        shift_q <= {shift_q[`TILE_CFG_BITS-2:0], up.sdata};
      end
      // Shadow copy taken on the chain-wide latch
      if (up.latch) begin
        cfg_q <= shift_q;
      end
    end
  end

  // Strobes pass through, data leaves from the top stage
  assign down.shift_en = up.shift_en;
  assign down.latch    = up.latch;
  assign down.run      = up.run;
  assign down.sdata    = shift_q[`TILE_CFG_BITS-1];

  // Field decode
  assign truth  = cfg_q[TT_LSB +: TT_W];
  assign use_ff = cfg_q[USE_BIT];

  // Input selectors
  always_comb begin
    for (int i = 0; i < LUT_K; i++) begin
      sel[i]    = lut_src_e'(cfg_q[i*SEL_W +: SEL_W]);
      lut_in[i] = pick_src(sel[i], west_bus, pads, ff_q);
    end
  end

  // Input 3 is the index MSB
  assign lut_out = truth[lut_in];

  // Output flip-flop, advances only while running
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ff_q <= 1'b0;
    end else if (up.run) begin
      ff_q <= lut_out;
    end
  end

  assign ff_out   = ff_q;
  assign tile_out = use_ff ? ff_q : lut_out;

  // Lanes move up one, tile output in lane 0
  assign east_bus = {west_bus[`FAB_LANES-2:0], tile_out};

endmodule

`default_nettype wire

// File: hw/pad_out_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "fabric_macros.svh"

module pad_out_stage
  import fabric_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  cfg_link_if.downstream        up,
  input  logic [`FAB_TILES-1:0] lut_outs,
  input  logic [`FAB_TILES-1:0] ff_outs,
  input  logic [`FAB_LANES-1:0] last_east,
  output logic [`FAB_TILES-1:0] gpio_out,
  output logic                  shift_out
);

  logic [`FAB_PAD_CFG_BITS-1:0] shift_q;
  logic [`FAB_PAD_CFG_BITS-1:0] cfg_q;
  pin_mode_e mode [`FAB_TILES];
  logic [`FAB_TILES-1:0] gpio_d;

  // Last segment of the chain
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shift_q <= '0;
      cfg_q   <= '0;
    end else begin
      if (up.shift_en) begin
        shift_q <= {shift_q[`FAB_PAD_CFG_BITS-2:0], up.sdata};
      end
      if (up.latch) begin
        cfg_q <= shift_q;
      end
    end
  end

  // Chain drains here
  assign shift_out = shift_q[`FAB_PAD_CFG_BITS-1];

  // Per-pin source mux
  always_comb begin
    for (int i = 0; i < `FAB_TILES; i++) begin
      mode[i] = pin_mode_e'(cfg_q[i*`OUT_CFG_BITS +: `OUT_CFG_BITS]);
      case (mode[i])
        PIN_LUT:  gpio_d[i] = lut_outs[i];
        PIN_FF:   gpio_d[i] = ff_outs[i];
        PIN_LANE: gpio_d[i] = last_east[i];
        default:  gpio_d[i] = 1'b0;
      endcase
    end
  end

  // Registered pins, one cycle behind their source
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_out <= '0;
    end else begin
      gpio_out <= gpio_d;
    end
  end

endmodule

`default_nettype wire

// File: include/fabric_macros.svh
`ifndef FABRIC_MACROS_SVH
`define FABRIC_MACROS_SVH

// Logic tiles in the row
`define FAB_TILES 4
// Tile-to-tile routing lanes
`define FAB_LANES 4
// Input pads per tile
`define FAB_PADS 2

// Four 3-bit selects, 16-bit truth table, use-ff bit
`define TILE_CFG_BITS 29
// Mode bits per output pin
`define OUT_CFG_BITS 2
// Pad stage segment length
`define FAB_PAD_CFG_BITS (`FAB_TILES * `OUT_CFG_BITS)
// Whole chain, 124 bits
`define FAB_CFG_TOTAL (`FAB_TILES * `TILE_CFG_BITS + `FAB_PAD_CFG_BITS)
// Loader bit counter width
`define FAB_CNT_W 8

`endif

// File: sim.f
+incdir+include
hw/fabric_pkg.sv
hw/cfg_link_if.sv
hw/cfg_loader.sv
hw/logic_tile.sv
hw/pad_out_stage.sv
hw/fabric_top.sv
tests/tb_fabric.sv

// File: tests/tb_fabric.sv
`timescale 1ns/1ps
`default_nettype none
`include "fabric_macros.svh"

module tb_fabric
  import fabric_pkg::*;
;

  logic clk;
  logic arst_n;
  logic en;
  logic cen;
  logic cset;
  logic shift_in;
  logic [`FAB_LANES-1:0] pad_west;
  logic [`FAB_TILES*`FAB_PADS-1:0] pad_in;
  logic shift_out;
  logic cfg_valid;
  logic cfg_error;
  logic [`FAB_TILES-1:0] gpio_out;

  // Configuration model with one entry per tile or pin
  logic [2:0] sel_cfg [`FAB_TILES][4];
  logic [15:0] tt_cfg [`FAB_TILES];
  logic use_cfg [`FAB_TILES];
  logic [1:0] pin_cfg [`FAB_TILES];
  // Predicted tile flip-flops and load status
  logic [`FAB_TILES-1:0] ff_model;
  logic valid_model;
  logic [31:0] rng_state;

  fabric_top dut0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .en        (en),
    .cen       (cen),
    .cset      (cset),
    .shift_in  (shift_in),
    .pad_west  (pad_west),
    .pad_in    (pad_in),
    .shift_out (shift_out),
    .cfg_valid (cfg_valid),
    .cfg_error (cfg_error),
    .gpio_out  (gpio_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog for the whole run
  initial begin
    #200000;
    $display("Simulation timed out before all checks finished");
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

  task automatic stop_on_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "Stopping at first mismatch");
  endtask

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Evaluates the row into {east bus of last tile, LUT outputs}
  function automatic logic [7:0] eval_row(input logic [3:0] west, input logic [7:0] pads);
    logic [3:0] bus;
    logic [3:0] luts;
    logic [3:0] idx;
    logic tout;
    bus = west;
    luts = '0;
    for (int t = 0; t < `FAB_TILES; t++) begin
      for (int i = 0; i < 4; i++) begin
        case (sel_cfg[t][i])
          SRC_WEST0, SRC_WEST1, SRC_WEST2, SRC_WEST3: idx[i] = bus[sel_cfg[t][i][1:0]];
          SRC_PAD0: idx[i] = pads[2*t];
          SRC_PAD1: idx[i] = pads[2*t+1];
          SRC_FF:   idx[i] = ff_model[t];
          default:  idx[i] = 1'b0;
        endcase
      end
      // Input 3 is the MSB of the truth-table index
      luts[t] = tt_cfg[t][idx];
      tout = use_cfg[t] ? ff_model[t] : luts[t];
      bus = {bus[2:0], tout};
    end
    return {bus, luts};
  endfunction

  // Expected pins from the model before the flip-flops advance
  function automatic logic [3:0] expect_pins(input logic [3:0] pw, input logic [7:0] pi);
    logic [7:0] row;
    logic [3:0] exp_gpio;
    row = eval_row(pw, pi);
    for (int i = 0; i < `FAB_TILES; i++) begin
      case (pin_cfg[i])
        PIN_LUT:  exp_gpio[i] = row[i];
        PIN_FF:   exp_gpio[i] = ff_model[i];
        PIN_LANE: exp_gpio[i] = row[4+i];
        default:  exp_gpio[i] = 1'b0;
      endcase
    end
    return exp_gpio;
  endfunction

  // Chain vector with tile 0 at the low end and the pad segment on top
  function automatic logic [`FAB_CFG_TOTAL-1:0] pack_cfg();
    logic [`FAB_CFG_TOTAL-1:0] v;
    int p;
    v = '0;
    p = 0;
    for (int t = 0; t < `FAB_TILES; t++) begin
      for (int i = 0; i < 4; i++) begin
        v[p +: 3] = sel_cfg[t][i];
        p = p + 3;
      end
      v[p +: 16] = tt_cfg[t];
      p = p + 16;
      v[p] = use_cfg[t];
      p = p + 1;
    end
    for (int i = 0; i < `FAB_TILES; i++) begin
      v[p +: 2] = pin_cfg[i];
      p = p + 2;
    end
    return v;
  endfunction

  task automatic randomize_tiles(input logic allow_ff);
    logic [31:0] r;
    for (int t = 0; t < `FAB_TILES; t++) begin
      r = next_rand();
      for (int i = 0; i < 4; i++) begin
        sel_cfg[t][i] = r[3*i +: 3];
      end
      tt_cfg[t] = r[31:16];
      use_cfg[t] = allow_ff & r[12];
    end
  endtask

  task automatic set_pins(input logic [1:0] mode);
    for (int i = 0; i < `FAB_TILES; i++) begin
      pin_cfg[i] = mode;
    end
  endtask

  // Starts and ends on a falling edge
  // MSB goes in first
  task automatic shift_bits(input logic [`FAB_CFG_TOTAL-1:0] v, input int n);
    for (int k = n - 1; k >= 0; k--) begin
      cen = 1'b1;
      shift_in = v[k];
      @(negedge clk);
    end
    cen = 1'b0;
    shift_in = 1'b0;
  endtask

  task automatic pulse_cset();
    cset = 1'b1;
    @(negedge clk);
    cset = 1'b0;
  endtask

  task automatic check_status(input logic exp_v, input logic exp_e);
    assert (cfg_valid === exp_v && cfg_error === exp_e)
      else stop_on_error($sformatf("cfg_valid %b cfg_error %b, expected %b %b",
                                   cfg_valid, cfg_error, exp_v, exp_e));
  endtask

  // Status must settle on the cycle right after cset
  task automatic load_cfg(input int nbits, input logic good);
    logic [`FAB_CFG_TOTAL-1:0] v;
    v = pack_cfg();
    en = 1'b0;
    shift_bits(v, nbits);
    pulse_cset();
    check_status(good, !good);
    valid_model = good;
  endtask

  // One fabric cycle with gpio_out checked a cycle after the drive
  task automatic step_and_check(input logic [3:0] pw, input logic [7:0] pi, input logic en_v);
    logic [7:0] row;
    logic [3:0] exp_gpio;
    pad_west = pw;
    pad_in = pi;
    en = en_v;
    row = eval_row(pw, pi);
    exp_gpio = expect_pins(pw, pi);
    if (en_v && valid_model) begin
      ff_model = row[3:0];
    end
    @(negedge clk);
    assert (gpio_out === exp_gpio)
      else stop_on_error($sformatf("gpio_out %b, expected %b", gpio_out, exp_gpio));
  endtask

  initial begin
    logic [31:0] r;
    logic [3:0] old_gpio;
    logic sent [$];
    arst_n = 1'b0;
    en = 1'b0;
    cen = 1'b0;
    cset = 1'b0;
    shift_in = 1'b0;
    pad_west = '0;
    pad_in = '0;
    ff_model = '0;
    valid_model = 1'b0;
    rng_state = 32'h5996cad5;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // Reset state with nothing loaded
    check_status(1'b0, 1'b0);
    assert (gpio_out === '0)
      else stop_on_error($sformatf("gpio_out %b after reset", gpio_out));

    // Good load with random LUTs and pins on LUT outputs
    randomize_tiles(1'b0);
    set_pins(PIN_LUT);
    load_cfg(`FAB_CFG_TOTAL, 1'b1);
    for (int n = 0; n < 50; n++) begin
      r = next_rand();
      step_and_check(r[3:0], r[11:4], 1'b0);
    end

    // Tile 0 as a toggle through its own flip-flop
    randomize_tiles(1'b0);
    set_pins(PIN_OFF);
    sel_cfg[0][0] = SRC_FF;
    sel_cfg[0][1] = SRC_ZERO;
    sel_cfg[0][2] = SRC_ZERO;
    sel_cfg[0][3] = SRC_ZERO;
    tt_cfg[0] = 16'h5555;
    use_cfg[0] = 1'b1;
    pin_cfg[0] = PIN_FF;
    load_cfg(`FAB_CFG_TOTAL, 1'b1);
    for (int n = 0; n < 24; n++) begin
      r = next_rand();
      // Runs of enabled and held cycles
      step_and_check(r[3:0], r[11:4], (n % 8) < 5);
    end

    // Pins on the east lanes of the last tile
    randomize_tiles(1'b1);
    set_pins(PIN_LANE);
    load_cfg(`FAB_CFG_TOTAL, 1'b1);
    for (int n = 0; n < 30; n++) begin
      r = next_rand();
      step_and_check(r[3:0], r[11:4], r[20]);
    end
    // Freeze the flip-flops and let the pins settle
    step_and_check(r[3:0], r[11:4], 1'b0);
    step_and_check(r[3:0], r[11:4], 1'b0);
    old_gpio = expect_pins(r[3:0], r[11:4]);

    // One bit short so the shadows keep the old setup
    randomize_tiles(1'b1);
    set_pins(PIN_LUT);
    load_cfg(`FAB_CFG_TOTAL - 1, 1'b0);
    for (int n = 0; n < 3; n++) begin
      assert (gpio_out === old_gpio)
        else stop_on_error($sformatf("gpio_out %b changed from %b", gpio_out, old_gpio));
      @(negedge clk);
    end

    // Chain tail repeats the head after a full chain of shifts
    for (int n = 1; n <= `FAB_CFG_TOTAL + 40; n++) begin
      r = next_rand();
      sent.push_back(r[7]);
      cen = 1'b1;
      shift_in = r[7];
      @(negedge clk);
      if (n >= `FAB_CFG_TOTAL) begin
        assert (shift_out === sent[n - `FAB_CFG_TOTAL])
          else stop_on_error($sformatf("shift_out %b after %0d shifts, expected %b",
                                       shift_out, n, sent[n - `FAB_CFG_TOTAL]));
      end
    end
    cen = 1'b0;
    @(negedge clk);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
